/* rtl/ahb_mtx_consts.svh */
`ifndef AHB_MTX_CONSTS_SVH
`define AHB_MTX_CONSTS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------

`define AHB_ADDR_W      32      // HADDR width
`define AHB_DATA_W      32      // HWDATA width
`define AHB_SIZE_W      3       // HSIZE width
`define AHB_BURST_W     3       // HBURST width
`define AHB_PROT_W      4       // HPROT width
`define AHB_MASTER_W    4       // HMASTER width
`define AHB_TRANS_W     2       // HTRANS width

// ----------------------------------------------------------------------
// Output stage port count
// ----------------------------------------------------------------------

// Priority decode in the arbiter is written for exactly three ports
`define AHB_NUM_PORTS   3       // Bus-switch inputs sharing the slave
`define AHB_PORT_W      2       // Bits to hold a port index

// ----------------------------------------------------------------------
// HTRANS encodings
// ----------------------------------------------------------------------

`define HTRANS_IDLE     2'b00   // No transfer
`define HTRANS_BUSY     2'b01   // Burst paused by master
`define HTRANS_NONSEQ   2'b10   // First beat or single
`define HTRANS_SEQ      2'b11   // Following beat of a burst

// A NONSEQ or SEQ both have bit 1 set
`define HTRANS_ACTIVE_BIT 1     // Bit marking a real transfer

`endif

/* rtl/ahb_mtx_pkg.sv */
`default_nettype none

`include "ahb_mtx_consts.svh"

package ahb_mtx_pkg;

  // --------------------------------------------------------------------
  // Field types
  // --------------------------------------------------------------------

  typedef logic [`AHB_ADDR_W-1:0]    haddr_t;     // Address
  typedef logic [`AHB_DATA_W-1:0]    hdata_t;     // Write data
  typedef logic [`AHB_TRANS_W-1:0]   htrans_t;    // Transfer type
  typedef logic [`AHB_SIZE_W-1:0]    hsize_t;     // Transfer size
  typedef logic [`AHB_BURST_W-1:0]   hburst_t;    // Burst type
  typedef logic [`AHB_PROT_W-1:0]    hprot_t;     // Protection control
  typedef logic [`AHB_MASTER_W-1:0]  hmaster_t;   // Master ID

  // Port bookkeeping
  typedef logic [`AHB_PORT_W-1:0]    port_idx_t;  // Input port number
  typedef logic [`AHB_NUM_PORTS-1:0] port_vec_t;  // One bit per input port

  // --------------------------------------------------------------------
  // Address phase bundle
  // --------------------------------------------------------------------

  // Everything a bus-switch input presents in its address phase,
  // routed as one unit through the output stage mux
  typedef struct packed {
    logic     sel;       // HSEL
    haddr_t   addr;      // HADDR
    htrans_t  trans;     // HTRANS
    logic     write;     // HWRITE
    hsize_t   size;      // HSIZE
    hburst_t  burst;     // HBURST, passed through only
    hprot_t   prot;      // HPROT
    hmaster_t master;    // HMASTER
    logic     mastlock;  // HMASTLOCK
  } ahb_addr_t;

endpackage

`default_nettype wire

/* rtl/ahb_out_arb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_consts.svh"

module ahb_out_arb
  import ahb_mtx_pkg::*;
(
  input  wire        HCLK,          // AHB system clock
  input  wire        HRESETn,       // Sync reset, active low
  input  port_vec_t  i_sel,         // Per-port HSEL
  input  port_vec_t  i_held_tran,   // Per-port held transfer flag
  input  ahb_addr_t  i_addr,        // Currently routed address phase
  input  wire        i_hready_mux,  // HREADYMUXM feedback
  output port_idx_t  o_addr_port,   // Granted port
  output logic       o_no_port      // No port granted
);

  // ----------------------------------------------------------------------
  // Requests and owner status
  // ----------------------------------------------------------------------

  port_vec_t req;            // Port requests
  logic      any_req;        // At least one port requesting
  port_idx_t win_port;       // Lowest requesting port
  logic      owner_req;      // Current owner still requesting
  logic      owner_burst;    // Owner mid burst
  logic      hsel_lock;      // Lock held across HSEL gaps
  logic      next_hsel_lock; // Next lock register value
  logic      hlock_arb;      // Mastlock as seen by arbitration
  logic      hold_owner;     // Keep current grant

  assign req     = i_sel & i_held_tran;  // Request needs both
  assign any_req = |req;

  // Fixed priority, port 0 first
  always_comb
  begin
    if (req[0])
      win_port = 2'd0;
    else if (req[1])
      win_port = 2'd1;
    else if (req[2])
      win_port = 2'd2;
    else
      win_port = o_addr_port;          // Index left alone when idle
  end

  // Request bit of the granted port
  always_comb
  begin
    case (o_addr_port)
      2'd0    : owner_req = req[0];
      2'd1    : owner_req = req[1];
      2'd2    : owner_req = req[2];
      default : owner_req = 1'b0;
    endcase
  end

  // BUSY or SEQ means the burst is not finished yet
  assign owner_burst = owner_req &
                       ((i_addr.trans == `HTRANS_BUSY) ||
                        (i_addr.trans == `HTRANS_SEQ));

  // ----------------------------------------------------------------------
  // Held-HSEL lock tracking
  // ----------------------------------------------------------------------

  // A master may address another slave mid lock, so HSEL drops while
  // HMASTLOCK stays high; the register remembers the lock started here
  always_comb
  begin
    if (i_addr.sel && i_addr.trans[`HTRANS_ACTIVE_BIT] && i_addr.mastlock)
      next_hsel_lock = 1'b1;           // Locked transfer seen
    else if (!i_addr.mastlock)
      next_hsel_lock = 1'b0;           // Lock sequence over
    else
      next_hsel_lock = hsel_lock;      // Keep during gaps
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (i_hready_mux)
      hsel_lock <= next_hsel_lock;
  end

  // Mastlock counts only when selected or already locked here
  assign hlock_arb = i_addr.mastlock & (hsel_lock | i_addr.sel);

  // Routed phase is zero with no grant, so neither term fires then
  assign hold_owner = hlock_arb | owner_burst;

  // ----------------------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------------------

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_addr_port <= '0;               // Port 0 after reset
      o_no_port   <= 1'b1;             // Nothing granted
    end
    else if (i_hready_mux)
    begin
      if (!hold_owner)
      begin
        o_addr_port <= win_port;
        o_no_port   <= ~any_req;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/ahb_addr_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_consts.svh"

module ahb_addr_mux
  import ahb_mtx_pkg::*;
(
  input  ahb_addr_t  i_addr_ports [0:`AHB_NUM_PORTS-1], // Per-port address phase
  input  port_idx_t  i_addr_port,   // Granted port
  input  wire        i_no_port,     // No port granted
  output ahb_addr_t  o_addr,        // Address phase to slave
  output port_vec_t  o_active       // One-hot active flags
);

  // ----------------------------------------------------------------------
  // Address and control routing
  // ----------------------------------------------------------------------

  // Whole bundle switches together, zeros when idle
  always_comb
  begin
    o_addr = '0;                       // HSELM low by default
    if (!i_no_port)
    begin
      case (i_addr_port)
        2'd0    : o_addr = i_addr_ports[0];
        2'd1    : o_addr = i_addr_ports[1];
        2'd2    : o_addr = i_addr_ports[2];
        default : o_addr = '0;         // Unused index
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Active flag decode
  // ----------------------------------------------------------------------

  // Tells each bus-switch input it owns the slave address phase
  always_comb
  begin
    o_active = '0;
    if (!i_no_port)
    begin
      case (i_addr_port)
        2'd0    : o_active = 3'b001;
        2'd1    : o_active = 3'b010;
        2'd2    : o_active = 3'b100;
        default : o_active = 3'b000;   // Unused index
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/ahb_data_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_consts.svh"

module ahb_data_stage
  import ahb_mtx_pkg::*;
(
  input  wire        HCLK,          // AHB system clock
  input  wire        HRESETn,       // Sync reset, active low
  input  wire        i_hsel,        // HSELM of current address phase
  input  port_idx_t  i_addr_port,   // Address-phase port
  input  hdata_t     i_wdata_ports [0:`AHB_NUM_PORTS-1], // Per-port write data
  input  wire        i_hreadyout,   // Slave HREADYOUT
  output hdata_t     o_hwdata,      // Write data to slave
  output logic       o_hready_mux   // HREADYMUXM
);

  port_idx_t data_port;   // Port owning the data phase
  logic      slave_sel;   // Slave in its data phase

  // ----------------------------------------------------------------------
  // Data-phase registers
  // ----------------------------------------------------------------------

  // Address phase moves into data phase on each completed transfer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= '0;
      slave_sel <= 1'b0;
    end
    else if (o_hready_mux)
    begin
      data_port <= i_addr_port;
      slave_sel <= i_hsel;
    end
  end

  // ----------------------------------------------------------------------
  // Write data mux
  // ----------------------------------------------------------------------

  always_comb
  begin
    case (data_port)
      2'd0    : o_hwdata = i_wdata_ports[0];
      2'd1    : o_hwdata = i_wdata_ports[1];
      2'd2    : o_hwdata = i_wdata_ports[2];
      default : o_hwdata = '0;         // Unused index
    endcase
  end

  // ----------------------------------------------------------------------
  // HREADYMUXM generation
  // ----------------------------------------------------------------------

  // Slave drives ready only while it owns a data phase
  assign o_hready_mux = slave_sel ? i_hreadyout : 1'b1;

endmodule

`default_nettype wire

/* rtl/ahb_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_consts.svh"

module ahb_out_stage
  import ahb_mtx_pkg::*;
(
  // Common AHB signals
  input  wire        HCLK,          // AHB system clock
  input  wire        HRESETn,       // Sync reset, active low

  // Bus-switch inputs
  input  ahb_addr_t  i_addr_ports [0:`AHB_NUM_PORTS-1], // Address phases
  input  port_vec_t  i_held_tran,   // Held transfer flags
  input  hdata_t     i_wdata_ports [0:`AHB_NUM_PORTS-1], // Write data

  // Shared slave
  input  wire        i_hreadyout,   // Slave HREADYOUT
  output ahb_addr_t  o_addr,        // Slave address phase
  output hdata_t     o_hwdata,      // Slave write data
  output logic       o_hready_mux,  // HREADYMUXM
  output port_vec_t  o_active       // Per-port active flags
);

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------

  port_vec_t port_sel;    // HSEL of each input
  ahb_addr_t sel_addr;    // Routed address phase
  port_idx_t addr_port;   // Granted port
  logic      no_port;     // No grant

  // Gather HSEL bits for the arbiter
  for (genvar p = 0; p < `AHB_NUM_PORTS; p++)
  begin : g_sel
    assign port_sel[p] = i_addr_ports[p].sel;
  end

  assign o_addr = sel_addr;

  // ----------------------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------------------

  ahb_out_arb u_out_arb (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_sel        (port_sel),
    .i_held_tran  (i_held_tran),
    .i_addr       (sel_addr),
    .i_hready_mux (o_hready_mux),
    .o_addr_port  (addr_port),
    .o_no_port    (no_port)
  );

  // ----------------------------------------------------------------------
  // Address-phase mux
  // ----------------------------------------------------------------------

  ahb_addr_mux u_addr_mux (
    .i_addr_ports (i_addr_ports),
    .i_addr_port  (addr_port),
    .i_no_port    (no_port),
    .o_addr       (sel_addr),
    .o_active     (o_active)
  );

  // ----------------------------------------------------------------------
  // Data-phase stage
  // ----------------------------------------------------------------------

  ahb_data_stage u_data_stage (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_hsel        (sel_addr.sel),
    .i_addr_port   (addr_port),
    .i_wdata_ports (i_wdata_ports),
    .i_hreadyout   (i_hreadyout),
    .o_hwdata      (o_hwdata),
    .o_hready_mux  (o_hready_mux)
  );

endmodule

`default_nettype wire

/* tb/tb_ahb_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mtx_consts.svh"

module tb_ahb_out_stage
  import ahb_mtx_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 600;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * TEST_CYCLES + 200;

  logic      HCLK = 1'b0;
  logic      HRESETn;
  ahb_addr_t addr_ports [0:`AHB_NUM_PORTS-1];   // Driven address phases
  port_vec_t held_tran;
  hdata_t    wdata_ports [0:`AHB_NUM_PORTS-1];
  logic      hreadyout;
  ahb_addr_t dut_addr;
  hdata_t    dut_hwdata;
  logic      dut_hready_mux;
  port_vec_t dut_active;

  // Reference model state
  port_idx_t m_port      = '0;     // Granted port
  logic      m_no_port   = 1'b1;
  logic      m_lock      = 1'b0;   // Held-HSEL lock
  port_idx_t m_data_port = '0;
  logic      m_slave_sel = 1'b0;
  logic      m_hrdy      = 1'b1;   // HREADYMUXM at the last edge

  integer    seed = 32'h64cbeba0;
  int        cycles      = 0;
  int        checks      = 0;
  int        errors      = 0;
  int        test_errors = 0;
  int        hold_hits   = 0;      // Holds against a lower request
  port_vec_t lock_state  = '0;     // Sticky mastlock per port
  port_vec_t prev_active = '0;
  port_idx_t prev_data_port = '0;

  always #20 HCLK = ~HCLK;         // 40 ns period

  ahb_out_stage dut_i (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_addr_ports  (addr_ports),
    .i_held_tran   (held_tran),
    .i_wdata_ports (wdata_ports),
    .i_hreadyout   (hreadyout),
    .o_addr        (dut_addr),
    .o_hwdata      (dut_hwdata),
    .o_hready_mux  (dut_hready_mux),
    .o_active      (dut_active)
  );

  // Run limit
  always @(posedge HCLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Random helpers and stimulus
  // ----------------------------------------------------------------------

  function automatic int pick(input int n);
    int r;
    r = $random(seed) % n;
    if (r < 0)
      r = -r;
    return r;
  endfunction

  function automatic logic chance(input int pct);
    return pick(100) < pct;
  endfunction

  // Mode 1 priority, 2 routing, 3 back-pressure, 4 lock and burst
  task automatic drive_inputs(input int mode);
    int r;
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
    begin
      addr_ports[p].sel   = chance(50);
      addr_ports[p].addr  = $random(seed);
      r = pick(8);
      if (mode == 1)
        addr_ports[p].trans = chance(50) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
      else if (mode == 4)
        addr_ports[p].trans = (r < 1) ? `HTRANS_IDLE :
                              (r < 3) ? `HTRANS_NONSEQ :
                              (r < 5) ? `HTRANS_BUSY : `HTRANS_SEQ;  // Bursts favored
      else
        addr_ports[p].trans = htrans_t'($random(seed));
      addr_ports[p].write  = chance(50);
      addr_ports[p].size   = hsize_t'($random(seed));
      addr_ports[p].burst  = hburst_t'($random(seed));
      addr_ports[p].prot   = hprot_t'($random(seed));
      addr_ports[p].master = hmaster_t'($random(seed));
      if (mode == 4 && chance(15))
        lock_state[p] = ~lock_state[p];   // Lock spans many cycles
      if (mode == 1)
        addr_ports[p].mastlock = 1'b0;
      else if (mode == 4)
        addr_ports[p].mastlock = lock_state[p];
      else
        addr_ports[p].mastlock = chance(15);
      held_tran[p]   = chance(50);
      wdata_ports[p] = $random(seed);
    end
    hreadyout = chance((mode == 3) ? 30 : 70);  // Often stalled in mode 3
  endtask

  // ----------------------------------------------------------------------
  // Reference model, one rising edge
  // ----------------------------------------------------------------------

  task automatic model_step();
    ahb_addr_t cur;
    port_vec_t req;
    port_idx_t win;
    logic      next_lock;
    logic      lock_arb;
    logic      burst;
    logic      hold;
    logic      lower;
    cur    = m_no_port ? '0 : addr_ports[m_port];
    m_hrdy = m_slave_sel ? hreadyout : 1'b1;
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      req[p] = addr_ports[p].sel & held_tran[p];
    win   = m_port;
    lower = 1'b0;
    for (int p = `AHB_NUM_PORTS - 1; p >= 0; p--)
      if (req[p])
        win = port_idx_t'(p);            // Lowest index wins
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      if (p < int'(m_port) && req[p])
        lower = 1'b1;
    if (!HRESETn)
    begin
      m_port = '0;
      m_no_port = 1'b1;
      m_lock = 1'b0;
      m_data_port = '0;
      m_slave_sel = 1'b0;
      m_hrdy = 1'b1;
    end
    else if (m_hrdy)
    begin
      if (cur.sel && (cur.trans == `HTRANS_NONSEQ || cur.trans == `HTRANS_SEQ) && cur.mastlock)
        next_lock = 1'b1;
      else if (!cur.mastlock)
        next_lock = 1'b0;
      else
        next_lock = m_lock;
      lock_arb = cur.mastlock & (m_lock | cur.sel);
      burst    = !m_no_port && req[m_port] &&
                 (cur.trans == `HTRANS_BUSY || cur.trans == `HTRANS_SEQ);
      hold     = lock_arb | burst;
      if (hold && !m_no_port && lower)
        hold_hits++;
      m_data_port = m_port;             // Old grant enters data phase
      m_slave_sel = cur.sel;
      m_lock      = next_lock;
      if (!hold)
      begin
        m_port    = win;
        m_no_port = (req == '0);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Checks and test sequencing
  // ----------------------------------------------------------------------

  task automatic value_error(input string name, input logic [95:0] exp_v,
                             input logic [95:0] act_v);
    $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
    errors++;
    test_errors++;
  endtask

  task automatic check_outputs();
    ahb_addr_t e_addr;
    port_vec_t e_active;
    hdata_t    e_hwdata;
    logic      e_hrdy;
    e_addr   = m_no_port ? '0 : addr_ports[m_port];
    e_active = m_no_port ? '0 : port_vec_t'(3'b001 << m_port);
    e_hwdata = wdata_ports[m_data_port];
    e_hrdy   = m_slave_sel ? hreadyout : 1'b1;
    checks++;
    if (dut_addr != e_addr)
      value_error("o_addr", {14'd0, e_addr}, {14'd0, dut_addr});
    if (dut_active != e_active)
      value_error("o_active", {93'd0, e_active}, {93'd0, dut_active});
    if (dut_hwdata != e_hwdata)
      value_error("o_hwdata", {64'd0, e_hwdata}, {64'd0, dut_hwdata});
    if (dut_hready_mux != e_hrdy)
      value_error("o_hready_mux", {95'd0, e_hrdy}, {95'd0, dut_hready_mux});
  endtask

  // Check after the falling edge, then drive the next inputs
  task automatic run_cycle(input int mode);
    @(negedge HCLK);
    model_step();
    if (!m_hrdy && dut_active != prev_active)
    begin
      $display("error at %0t ns: o_active changed while HREADYMUXM was low", $time);
      errors++;
      test_errors++;
    end
    if (!m_hrdy && dut_i.u_data_stage.data_port != prev_data_port)
    begin
      $display("error at %0t ns: data port moved while HREADYMUXM was low", $time);
      errors++;
      test_errors++;
    end
    check_outputs();
    prev_active    = dut_active;
    prev_data_port = dut_i.u_data_stage.data_port;
    drive_inputs(mode);
  endtask

  task automatic report_test(input string name);
    $display("test %-22s finished, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  initial
  begin
    HRESETn = 1'b0;
    drive_inputs(2);                    // Every input set at time zero
    repeat (RESET_CYCLES)
      run_cycle(2);
    HRESETn = 1'b1;
    repeat (2)
      run_cycle(1);
    report_test("reset_state");

    repeat (TEST_CYCLES)
      run_cycle(1);
    report_test("priority_grant");
    repeat (TEST_CYCLES)
      run_cycle(2);
    report_test("address_routing");
    repeat (TEST_CYCLES)
      run_cycle(3);
    report_test("back_pressure");

    hold_hits = 0;
    repeat (TEST_CYCLES)
      run_cycle(4);
    if (hold_hits == 0)
    begin
      $display("error: no lock or burst hold against a lower-numbered request was seen");
      errors++;
      test_errors++;
    end
    report_test("lock_burst_hold");

    $display("summary: %0d checks, %0d errors, %0d holds in last test",
             checks, errors, hold_hits);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/ahb_mtx_pkg.sv
rtl/ahb_out_arb.sv
rtl/ahb_addr_mux.sv
rtl/ahb_data_stage.sv
rtl/ahb_out_stage.sv
tb/tb_ahb_out_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the output stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f \
  --top-module tb_ahb_out_stage -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
  exit 0
fi
exit 1
